/* verilog/pat_pkg.sv */
package pat_pkg;

	// ==================================================
	// widths
	// ==================================================
	localparam int D_WIDTH = 8; // fixed, immediate field is 8 bits
	localparam int I_WIDTH = 20; // one instruction
	localparam int NUM_IN_PORTS = 3;
	localparam int CTRL_PC_WIDTH = 10; // pc copy that travels with a decoded slot

	// ==================================================
	// opcodes
	// ==================================================
	typedef enum logic [3:0] {
		OP_OR = 4'd0, OP_AND = 4'd1, OP_ADDM = 4'd2, OP_SUBM = 4'd3,
		OP_ADD = 4'd4, OP_SUB = 4'd5, OP_LDI = 4'd6, OP_LDM = 4'd7,
		OP_BF = 4'd8, OP_BB = 4'd9, OP_STM = 4'd11, OP_ORM = 4'd13,
		OP_ANDM = 4'd14,
		OP_I3 = 4'd15 // escape into i3 space
	} op_i8_e; // 10 and 12 are free, they decode as nop

	typedef enum logic [3:0] {
		I3_SHL = 4'd0, I3_SHLO = 4'd1, I3_SHR = 4'd2, I3_ASR = 4'd3,
		I3_IN = 4'd5, I3_OUT = 4'd8,
		I3_I0 = 4'd15 // escape into i0 space
	} op_i3_e;

	typedef enum logic [3:0] {
		I0_NOT = 4'd0, I0_TEST = 4'd2, I0_NOP = 4'd15
	} op_i0_e;

	typedef enum logic [1:0] {
		COND_Z = 2'd0, // z set
		COND_NZ = 2'd1, // z clear
		COND_N = 2'd2, // n set
		COND_AL = 2'd3 // always
	} cond_e;

	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_ADD, ALU_SUB, ALU_NOT,
		ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {SRC_IMM, SRC_MEM, SRC_IN} src_e; // alu b operand

	// instruction word, msb first
	typedef struct packed {
		logic [4:0] fieldp; // reserved
		cond_e cond; // branch condition
		logic field_op; // reserved
		op_i8_e opcode;
		logic [7:0] imm; // i3: {op, x, operand}, i0: {x, op}
	} instr_t;

	localparam instr_t INSTR_NOP = 20'h06ff5; // i8 and i3 prefixes, i0 slot

	// decoded slot, all zero means nothing happens
	typedef struct packed {
		alu_op_e alu_op;
		src_e src;
		logic writes_acc;
		logic mem_write; // stm
		logic set_flags; // test
		logic out_strobe; // out
		logic branch; // bf or bb
		logic branch_back; // bb
		cond_e cond;
		logic [D_WIDTH-1:0] imm;
		logic [CTRL_PC_WIDTH-1:0] pc; // own address, base for branch target
	} ctrl_t;

endpackage

/* verilog/inst_mem.sv */
`timescale 1ns/1ps

// two instructions per line, written by the host, read by fetch
module inst_mem import pat_pkg::*; #(
	parameter int i_adr_width = 10
) (
	input logic clk,
	input logic [i_adr_width-2:0] i_read_adr, // line address, pc without bit 0
	input logic [i_adr_width-2:0] i_write_adr,
	input logic i_write, // level, one line per clock while high
	input instr_t [1:0] i_write_data,
	output instr_t [1:0] o_line
);

	localparam int num_lines = 2 ** (i_adr_width - 1);

	instr_t [1:0] mem [num_lines]; // [0] is the even address

	assign o_line = mem[i_read_adr]; // async read

	always_ff @(posedge clk)
	begin
		if (i_write)
			mem[i_write_adr] <= i_write_data;
	end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

// accumulator alu, a is always the accumulator
module alu import pat_pkg::*; (
	input logic [D_WIDTH-1:0] i_a,
	input logic [D_WIDTH-1:0] i_b,
	input alu_op_e i_op,
	output logic [D_WIDTH-1:0] o_y
);

	logic [2:0] shamt; // shifts only look at b[2:0]
	logic [D_WIDTH-1:0] shl_y;
	logic [D_WIDTH-1:0] shlo_y;
	logic [D_WIDTH-1:0] shr_y;
	logic [D_WIDTH-1:0] asr_y;
	logic [D_WIDTH-1:0] shift_y;
	logic is_sub;
	logic [D_WIDTH-1:0] addsub_y;

	// ==================================================
	// shifter
	// ==================================================
	assign shamt = i_b[2:0];
	assign shl_y = i_a << shamt;
	assign shlo_y = shl_y | ~({D_WIDTH{1'b1}} << shamt); // ones into the vacated bits
	assign shr_y = i_a >> shamt;
	assign asr_y = $signed(i_a) >>> shamt; // sign fill

	always_comb
	begin
		case (i_op)
			ALU_SHL: shift_y = shl_y;
			ALU_SHLO: shift_y = shlo_y;
			ALU_SHR: shift_y = shr_y;
			default: shift_y = asr_y;
		endcase
	end

	// one adder for add and sub, invert b and carry in on sub
	assign is_sub = (i_op == ALU_SUB);
	assign addsub_y = i_a + (is_sub ? ~i_b : i_b) + D_WIDTH'(is_sub);

	// ==================================================
	// result select
	// ==================================================
	always_comb
	begin
		case (i_op)
			ALU_OR: o_y = i_a | i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_ADD, ALU_SUB: o_y = addsub_y;
			ALU_NOT: o_y = ~i_a;
			ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR: o_y = shift_y;
			default: o_y = i_b; // pass_b, loads and in
		endcase
	end

endmodule

/* verilog/instruction_fetch.sv */
`timescale 1ns/1ps

// pc, line read and half select into one fetch register
module instruction_fetch import pat_pkg::*; #(
	parameter int i_adr_width = 10
) (
	input logic clk,
	input logic reset,
	input logic i_jump, // taken branch in execute
	input logic [i_adr_width-1:0] i_jump_target,
	// host write port
	input logic i_imem_write,
	input logic [i_adr_width-2:0] i_imem_write_adr,
	input instr_t [1:0] i_imem_write_data,
	output logic [i_adr_width-1:0] o_pc,
	output instr_t o_instr, // fetch register
	output logic [i_adr_width-1:0] o_instr_pc // address of o_instr
);

	logic [i_adr_width-1:0] pc;
	logic [i_adr_width-1:0] pc_next;
	instr_t [1:0] line; // both halves of the current line
	instr_t half; // the one pc points at

	// ==================================================
	// instruction store
	// ==================================================
	inst_mem #(
		.i_adr_width(i_adr_width)
	) inst_mem_i (
		.clk(clk),
		.i_read_adr(pc[i_adr_width-1:1]),
		.i_write_adr(i_imem_write_adr),
		.i_write(i_imem_write),
		.i_write_data(i_imem_write_data),
		.o_line(line)
	);

	assign half = line[pc[0]]; // even pc takes the low half

	// ==================================================
	// program counter
	// ==================================================
	assign pc_next = i_jump ? i_jump_target : pc + i_adr_width'(1);

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_next;
	end

	assign o_pc = pc;

	// fetch register, a jump kills whatever was read this cycle
	always_ff @(posedge clk)
	begin
		if (reset || i_jump)
			o_instr <= INSTR_NOP;
		else
			o_instr <= half;
	end

	// address rides along, only meaningful next to a live instruction
	always_ff @(posedge clk)
	begin
		o_instr_pc <= pc;
	end

	// the younger slot never survives a redirect
	a_squash_after_jump: assert property (
		@(posedge clk) disable iff (reset)
		i_jump |=> (o_instr == INSTR_NOP)
	);

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps

// classify i8 / i3 / i0 and register the control slot
module decoder import pat_pkg::*; #(
	parameter int i_adr_width = 10
) (
	input logic clk,
	input logic reset,
	input instr_t i_instr,
	input logic [i_adr_width-1:0] i_instr_pc,
	input logic i_jump, // squash the slot headed for execute
	output ctrl_t o_ctrl
);

	op_i3_e op_i3;
	op_i0_e op_i0;
	logic is_i8;
	logic is_i3;
	logic live; // slot does something
	ctrl_t ctrl_d;

	assign op_i3 = op_i3_e'(i_instr.imm[7:4]);
	assign op_i0 = op_i0_e'(i_instr.imm[3:0]);
	assign is_i8 = (i_instr.opcode != OP_I3);
	assign is_i3 = !is_i8 && (op_i3 != I3_I0); // anything left is i0

	always_comb
	begin
		ctrl_d = '0;
		ctrl_d.cond = i_instr.cond; // only looked at for branches
		ctrl_d.pc = CTRL_PC_WIDTH'(i_instr_pc);
		if (is_i8)
		begin
			ctrl_d.imm = i_instr.imm;
			case (i_instr.opcode)
				OP_OR, OP_ORM: ctrl_d.alu_op = ALU_OR;
				OP_AND, OP_ANDM: ctrl_d.alu_op = ALU_AND;
				OP_ADD, OP_ADDM: ctrl_d.alu_op = ALU_ADD;
				OP_SUB, OP_SUBM: ctrl_d.alu_op = ALU_SUB;
				default: ctrl_d.alu_op = ALU_PASS_B; // ldi, ldm
			endcase
			// memory operand forms
			if (i_instr.opcode inside {OP_ORM, OP_ANDM, OP_ADDM, OP_SUBM, OP_LDM})
				ctrl_d.src = SRC_MEM;
			ctrl_d.writes_acc = i_instr.opcode inside {OP_OR, OP_AND, OP_ADD, OP_SUB,
				OP_ORM, OP_ANDM, OP_ADDM, OP_SUBM, OP_LDI, OP_LDM};
			ctrl_d.mem_write = (i_instr.opcode == OP_STM);
			ctrl_d.branch = (i_instr.opcode inside {OP_BF, OP_BB}); // cond tested later
			ctrl_d.branch_back = (i_instr.opcode == OP_BB);
		end
		else if (is_i3)
		begin
			ctrl_d.imm = D_WIDTH'(i_instr.imm[2:0]); // 3 bit operand only
			case (op_i3)
				I3_SHL: ctrl_d.alu_op = ALU_SHL;
				I3_SHLO: ctrl_d.alu_op = ALU_SHLO;
				I3_SHR: ctrl_d.alu_op = ALU_SHR;
				I3_ASR: ctrl_d.alu_op = ALU_ASR;
				default: ctrl_d.alu_op = ALU_PASS_B; // in
			endcase
			if (op_i3 == I3_IN)
				ctrl_d.src = SRC_IN;
			ctrl_d.writes_acc = op_i3 inside {I3_SHL, I3_SHLO, I3_SHR, I3_ASR, I3_IN};
			ctrl_d.out_strobe = (op_i3 == I3_OUT);
		end
		else
		begin
			ctrl_d.alu_op = ALU_NOT;
			ctrl_d.writes_acc = (op_i0 == I0_NOT);
			ctrl_d.set_flags = (op_i0 == I0_TEST); // nop and unknown fall through
		end
		// undefined codes collapse to the zero slot
		live = ctrl_d.writes_acc | ctrl_d.mem_write | ctrl_d.set_flags
			| ctrl_d.out_strobe | ctrl_d.branch;
		if (!live)
			ctrl_d = '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset || i_jump)
			o_ctrl <= '0; // bubble
		else
			o_ctrl <= ctrl_d;
	end

	// one destination per slot, execute relies on it
	a_single_dest: assert property (
		@(posedge clk) disable iff (reset)
		!(o_ctrl.writes_acc && o_ctrl.mem_write)
	);

endmodule

/* verilog/execute.sv */
`timescale 1ns/1ps

// accumulator, flags, data memory, output port and branch resolve
module execute import pat_pkg::*; #(
	parameter int i_adr_width = 10,
	parameter int d_adr_width = 4
) (
	input logic clk,
	input logic reset,
	input ctrl_t i_ctrl,
	input logic [D_WIDTH-1:0] i_in_port [NUM_IN_PORTS],
	output logic o_jump, // combinational, during the branch's own cycle
	output logic [i_adr_width-1:0] o_jump_target,
	output logic [D_WIDTH-1:0] o_out_port,
	output logic o_out_strobe
);

	localparam int dmem_words = 2 ** d_adr_width;

	logic [D_WIDTH-1:0] acc;
	logic flag_z;
	logic flag_n;
	logic [D_WIDTH-1:0] dmem [dmem_words];
	logic [d_adr_width-1:0] dmem_adr;
	logic [D_WIDTH-1:0] dmem_rd;
	logic [D_WIDTH-1:0] in_sel;
	logic [D_WIDTH-1:0] alu_b;
	logic [D_WIDTH-1:0] alu_y;
	logic cond_ok;
	logic [i_adr_width-1:0] br_pc;
	logic [i_adr_width-1:0] br_fwd;
	logic [i_adr_width-1:0] br_back;

	// ==================================================
	// operand b
	// ==================================================
	assign dmem_adr = i_ctrl.imm[d_adr_width-1:0]; // low imm bits
	assign dmem_rd = dmem[dmem_adr];

	always_ff @(posedge clk)
	begin
		if (i_ctrl.mem_write)
			dmem[dmem_adr] <= acc; // stm
	end

	// one-hot port select, anything else reads port 0
	always_comb
	begin
		case (i_ctrl.imm[2:0])
			3'b010: in_sel = i_in_port[1];
			3'b100: in_sel = i_in_port[2];
			default: in_sel = i_in_port[0];
		endcase
	end

	always_comb
	begin
		case (i_ctrl.src)
			SRC_MEM: alu_b = dmem_rd;
			SRC_IN: alu_b = in_sel;
			default: alu_b = i_ctrl.imm;
		endcase
	end

	alu alu_i (
		.i_a(acc),
		.i_b(alu_b),
		.i_op(i_ctrl.alu_op),
		.o_y(alu_y)
	);

	// ==================================================
	// commit
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			o_out_strobe <= 1'b0;
		end
		else
		begin
			if (i_ctrl.writes_acc)
				acc <= alu_y;
			if (i_ctrl.set_flags)
			begin
				flag_z <= (acc == '0); // test looks at acc as it stands
				flag_n <= acc[D_WIDTH-1];
			end
			o_out_strobe <= i_ctrl.out_strobe; // single cycle pulse
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_ctrl.out_strobe)
			o_out_port <= acc;
	end

	// branch against flags already committed
	always_comb
	begin
		case (i_ctrl.cond)
			COND_Z: cond_ok = flag_z;
			COND_NZ: cond_ok = !flag_z;
			COND_N: cond_ok = flag_n;
			COND_AL: cond_ok = 1'b1;
			default: cond_ok = 1'b1;
		endcase
	end

	assign o_jump = i_ctrl.branch && cond_ok;

	assign br_pc = i_ctrl.pc[i_adr_width-1:0];
	assign br_fwd = br_pc + {{(i_adr_width-D_WIDTH){i_ctrl.imm[D_WIDTH-1]}}, i_ctrl.imm};
	assign br_back = br_pc - {{(i_adr_width-D_WIDTH){1'b0}}, i_ctrl.imm}; // bb 0 spins
	assign o_jump_target = i_ctrl.branch_back ? br_back : br_fwd;

	// decoder squash keeps a second jump from following straight on
	a_jump_then_bubble: assert property (
		@(posedge clk) disable iff (reset)
		o_jump |-> i_ctrl.branch ##1 !o_jump
	);

endmodule

/* verilog/pat.sv */
`timescale 1ns/1ps

// 3 stage accumulator core: fetch, decode, execute
module pat import pat_pkg::*; #(
	parameter int i_adr_width = 10,
	parameter int d_adr_width = 4
) (
	input logic clk,
	input logic reset,
	input logic i_imem_write, // host loads program lines
	input logic [i_adr_width-2:0] i_imem_write_adr,
	input instr_t [1:0] i_imem_write_data,
	input logic [D_WIDTH-1:0] i_in_port [NUM_IN_PORTS],
	output logic [D_WIDTH-1:0] o_out_port,
	output logic o_out_strobe,
	output logic [i_adr_width-1:0] o_pc,
	output logic o_jump
);

	instr_t fetched_instr;
	logic [i_adr_width-1:0] fetched_pc;
	ctrl_t ctrl;
	logic jump;
	logic [i_adr_width-1:0] jump_target;

	instruction_fetch #(
		.i_adr_width(i_adr_width)
	) instruction_fetch_i (
		.clk(clk),
		.reset(reset),
		.i_jump(jump),
		.i_jump_target(jump_target),
		.i_imem_write(i_imem_write),
		.i_imem_write_adr(i_imem_write_adr),
		.i_imem_write_data(i_imem_write_data),
		.o_pc(o_pc),
		.o_instr(fetched_instr),
		.o_instr_pc(fetched_pc)
	);

	decoder #(
		.i_adr_width(i_adr_width)
	) decoder_i (
		.clk(clk),
		.reset(reset),
		.i_instr(fetched_instr),
		.i_instr_pc(fetched_pc),
		.i_jump(jump),
		.o_ctrl(ctrl)
	);

	execute #(
		.i_adr_width(i_adr_width),
		.d_adr_width(d_adr_width)
	) execute_i (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_in_port(i_in_port),
		.o_jump(jump),
		.o_jump_target(jump_target),
		.o_out_port(o_out_port),
		.o_out_strobe(o_out_strobe)
	);

	assign o_jump = jump;

endmodule

/* verification/pat_tb.sv */
`timescale 1ns/1ps

// directed tests for the pat accumulator core
module pat_tb import pat_pkg::*; ();

	// ==================================================
	// per test cycle limits
	// ==================================================
	localparam int limit_alu = 100;
	localparam int limit_mem = 100;
	localparam int limit_shift = 250;
	localparam int limit_in = 60;
	localparam int limit_branch = 250;
	localparam int margin = 400; // program loads, reset and tail cycles
	localparam int watchdog_cycles = limit_alu + limit_mem + limit_shift + limit_in
		+ limit_branch + margin;

	logic clk = 1'b0;
	logic reset;
	logic imem_write;
	logic [8:0] imem_write_adr; // line address
	instr_t [1:0] imem_write_data;
	logic [D_WIDTH-1:0] in_port [NUM_IN_PORTS];
	logic [D_WIDTH-1:0] out_port;
	logic out_strobe;
	logic [9:0] pc;
	logic jump;

	logic [31:0] lfsr_state;
	instr_t prog[$]; // program being built
	logic [7:0] exp_q[$]; // outputs it has to produce, in order
	int pass_count;
	int fail_count;

	always #5 clk = ~clk; // 10 ns period

	pat #(
		.i_adr_width(10),
		.d_adr_width(4)
	) pat_i (
		.clk(clk),
		.reset(reset),
		.i_imem_write(imem_write),
		.i_imem_write_adr(imem_write_adr),
		.i_imem_write_data(imem_write_data),
		.i_in_port(in_port),
		.o_out_port(out_port),
		.o_out_strobe(out_strobe),
		.o_pc(pc),
		.o_jump(jump)
	);

	// ==================================================
	// stimulus helpers
	// ==================================================
	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [7:0] rand_bits(int n);
		logic [7:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[6:0], fb};
		end
		return r;
	endfunction

	function automatic instr_t i8_word(logic [3:0] op, logic [7:0] imm);
		return {5'd0, 2'd0, 1'b0, op, imm};
	endfunction

	function automatic instr_t branch_word(logic [3:0] op, logic [1:0] cond, logic [7:0] off);
		return {5'd0, cond, 1'b0, op, off};
	endfunction

	function automatic instr_t i3_word(logic [3:0] op3, logic [2:0] operand);
		return {5'd0, 2'd0, 1'b0, 4'hf, op3, 1'b0, operand}; // i3 prefix in opcode
	endfunction

	function automatic instr_t i0_word(logic [3:0] op0);
		return {5'd0, 2'd0, 1'b0, 4'hf, 4'hf, op0};
	endfunction

	function automatic void out_expect(logic [7:0] v);
		prog.push_back(i3_word(I3_OUT, 3'd0));
		exp_q.push_back(v);
	endfunction

	// reference shift rules, amount 0 to 7
	function automatic logic [7:0] shift_model(op_i3_e op3, logic [7:0] v, int amt);
		logic [7:0] r;
		case (op3)
			I3_SHL: r = v << amt;
			I3_SHLO: r = (v << amt) | (8'hff >> (8 - amt)); // ones shifted in
			I3_SHR: r = v >> amt;
			default:
			begin
				r = v >> amt;
				if (v[7])
					r = r | ~(8'hff >> amt); // sign copies on top
			end
		endcase
		return r;
	endfunction

	// writes the program two per line while reset is held
	task automatic load_program();
		int line;
		prog.push_back(branch_word(OP_BB, COND_AL, 8'd0)); // parks the core
		@(negedge clk);
		reset = 1'b1;
		for (line = 0; line < (prog.size() + 1) / 2; line++)
		begin
			imem_write = 1'b1;
			imem_write_adr = 9'(line);
			imem_write_data[0] = prog[2 * line]; // even address
			imem_write_data[1] = (2 * line + 1 < prog.size()) ? prog[2 * line + 1] : INSTR_NOP;
			@(negedge clk);
		end
		imem_write = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic run_and_check(string name, int limit);
		logic [7:0] got[$];
		int cycles;
		int errors;
		logic [9:0] park_pc; // address of the closing bb 0
		logic [9:0] exp_pc;
		load_program();
		park_pc = 10'(prog.size() - 1);
		errors = 0;
		cycles = 0;
		reset = 1'b0;
		while (got.size() < exp_q.size() && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
			if (out_strobe)
				got.push_back(out_port);
		end
		if (got.size() < exp_q.size())
		begin
			$display("%s: gave up after %0d cycles with %0d of %0d outputs seen",
				name, cycles, got.size(), exp_q.size());
			errors++;
		end
		else
		begin
			// anything after the last output is a leak from a squashed slot
			// every program ends out, bb 0 so the loop phase is fixed here
			for (int t = 0; t < 8; t++)
			begin
				@(negedge clk);
				if (out_strobe)
					got.push_back(out_port);
				exp_pc = park_pc + 10'(t % 3); // bb 0 resolves two fetches later
				if (pc !== exp_pc)
				begin
					$display("[FAIL] %s parked pc expected 0x%03h actual 0x%03h",
						name, exp_pc, pc);
					errors++;
				end
				if (jump !== (t % 3 == 2))
				begin
					$display("[FAIL] %s jump at pc 0x%03h expected %0b actual %0b",
						name, exp_pc, (t % 3 == 2), jump);
					errors++;
				end
			end
		end
		for (int i = 0; i < exp_q.size() && i < got.size(); i++)
		begin
			if (got[i] !== exp_q[i])
			begin
				$display("[FAIL] %s output %0d expected 0x%02h actual 0x%02h",
					name, i, exp_q[i], got[i]);
				errors++;
			end
		end
		if (got.size() > exp_q.size())
		begin
			$display("%s: %0d outputs seen but only %0d expected",
				name, got.size(), exp_q.size());
			errors++;
		end
		if (errors == 0)
		begin
			pass_count++;
			$display("%s: pass, %0d outputs", name, got.size());
		end
		else
		begin
			fail_count++;
			$display("%s: %0d errors", name, errors);
		end
		prog.delete();
		exp_q.delete();
	endtask

	// ==================================================
	// directed tests
	// ==================================================
	task automatic imm_alu_test();
		logic [7:0] model; // running accumulator
		logic [7:0] r;
		for (int round = 0; round < 3; round++)
		begin
			r = rand_bits(8);
			prog.push_back(i8_word(OP_LDI, r));
			model = r;
			out_expect(model);
			r = rand_bits(8);
			prog.push_back(i8_word(OP_ADD, r));
			model = model + r; // 8 bit wrap
			out_expect(model);
			r = rand_bits(8);
			prog.push_back(i8_word(OP_SUB, r));
			model = model - r;
			out_expect(model);
			r = rand_bits(8);
			prog.push_back(i8_word(OP_OR, r));
			model = model | r;
			out_expect(model);
			r = rand_bits(8);
			prog.push_back(i8_word(OP_AND, r));
			model = model & r;
			out_expect(model);
			prog.push_back(i0_word(I0_NOT));
			model = ~model;
			out_expect(model);
		end
		run_and_check("imm_alu", limit_alu);
	endtask

	task automatic data_memory_test();
		logic [7:0] mem_model [16];
		logic [3:0] adr [4];
		logic [7:0] model;
		adr = '{4'd3, 4'd7, 4'd10, 4'd14};
		for (int i = 0; i < 4; i++)
		begin
			mem_model[adr[i]] = rand_bits(8);
			prog.push_back(i8_word(OP_LDI, mem_model[adr[i]]));
			prog.push_back(i8_word(OP_STM, {4'd0, adr[i]}));
		end
		prog.push_back(i8_word(OP_LDM, {4'd0, adr[0]}));
		model = mem_model[adr[0]];
		out_expect(model);
		prog.push_back(i8_word(OP_ADDM, {4'd0, adr[1]}));
		model = model + mem_model[adr[1]];
		out_expect(model);
		prog.push_back(i8_word(OP_SUBM, {4'd0, adr[2]}));
		model = model - mem_model[adr[2]];
		out_expect(model);
		prog.push_back(i8_word(OP_ORM, {4'd0, adr[3]}));
		model = model | mem_model[adr[3]];
		out_expect(model);
		prog.push_back(i8_word(OP_ANDM, {4'hf, adr[1]})); // upper imm bits ignored
		model = model & mem_model[adr[1]];
		out_expect(model);
		// store then load straight back
		prog.push_back(i8_word(OP_STM, {4'd0, adr[2]}));
		mem_model[adr[2]] = model;
		prog.push_back(i8_word(OP_LDI, 8'd0));
		prog.push_back(i8_word(OP_LDM, {4'd0, adr[2]}));
		out_expect(mem_model[adr[2]]);
		run_and_check("data_memory", limit_mem);
	endtask

	task automatic shift_test();
		op_i3_e ops [4];
		logic [7:0] v;
		ops = '{I3_SHL, I3_SHLO, I3_SHR, I3_ASR};
		for (int amt = 0; amt < 8; amt++)
		begin
			v = rand_bits(8);
			v[7] = amt[0]; // both signs for asr
			for (int k = 0; k < 4; k++)
			begin
				prog.push_back(i8_word(OP_LDI, v));
				prog.push_back(i3_word(ops[k], 3'(amt)));
				out_expect(shift_model(ops[k], v, amt));
			end
		end
		run_and_check("shift", limit_shift);
	endtask

	task automatic input_select_test();
		for (int i = 0; i < NUM_IN_PORTS; i++)
			in_port[i] = rand_bits(8);
		prog.push_back(i3_word(I3_IN, 3'b001));
		out_expect(in_port[0]);
		prog.push_back(i3_word(I3_IN, 3'b010));
		out_expect(in_port[1]);
		prog.push_back(i3_word(I3_IN, 3'b100));
		out_expect(in_port[2]);
		prog.push_back(i3_word(I3_IN, 3'b011)); // not one-hot, falls back to port 0
		out_expect(in_port[0]);
		run_and_check("input_select", limit_in);
	endtask

	// test, then bf over two outs that only show when not taken
	task automatic branch_case(logic [7:0] v, logic [1:0] cond, logic [7:0] marker);
		logic taken;
		case (cond)
			2'd0: taken = (v == 8'd0);
			2'd1: taken = (v != 8'd0);
			2'd2: taken = v[7];
			default: taken = 1'b1;
		endcase
		prog.push_back(i8_word(OP_LDI, v));
		prog.push_back(i0_word(I0_TEST));
		prog.push_back(branch_word(OP_BF, cond, 8'd3));
		prog.push_back(i3_word(I3_OUT, 3'd0));
		prog.push_back(i3_word(I3_OUT, 3'd0));
		if (!taken)
		begin
			exp_q.push_back(v);
			exp_q.push_back(v);
		end
		prog.push_back(i8_word(OP_LDI, marker)); // branch target
		out_expect(marker);
	endtask

	task automatic branch_test();
		logic [7:0] r;
		logic [7:0] n;
		r = {1'b0, rand_bits(7)} | 8'h01; // positive, nonzero
		branch_case(8'd0, COND_Z, 8'hc0);
		branch_case(r, COND_Z, 8'hc1);
		branch_case(8'd0, COND_NZ, 8'hc2);
		branch_case(r, COND_NZ, 8'hc3);
		branch_case(r | 8'h80, COND_N, 8'hc4);
		branch_case(r, COND_N, 8'hc5);
		branch_case(r, COND_AL, 8'hc6);
		// countdown loop, bb nz back to the out
		n = 8'd3 + rand_bits(3);
		prog.push_back(i8_word(OP_LDI, n));
		prog.push_back(i3_word(I3_OUT, 3'd0));
		prog.push_back(i8_word(OP_SUB, 8'd1));
		prog.push_back(i0_word(I0_TEST));
		prog.push_back(branch_word(OP_BB, COND_NZ, 8'd3));
		for (int i = n; i > 0; i--)
			exp_q.push_back(8'(i));
		prog.push_back(i8_word(OP_LDI, 8'hd0)); // in both squashed slots of each pass
		out_expect(8'hd0);
		run_and_check("branch", limit_branch);
	endtask

	// ==================================================
	// sequence and watchdog
	// ==================================================
	initial
	begin
		reset = 1'b1;
		imem_write = 1'b0;
		imem_write_adr = '0;
		imem_write_data = {INSTR_NOP, INSTR_NOP};
		for (int i = 0; i < NUM_IN_PORTS; i++)
			in_port[i] = '0;
		lfsr_state = 32'h96fb;
		pass_count = 0;
		fail_count = 0;
		repeat (2) @(negedge clk);
		imm_alu_test();
		data_memory_test();
		shift_test();
		input_select_test();
		branch_test();
		$display("tests %0d, passed %0d, failed %0d", pass_count + fail_count,
			pass_count, fail_count);
		if (fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		#(watchdog_cycles * 10);
		$display("watchdog expired, run still going after %0d cycles", watchdog_cycles);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* src.f */
verilog/pat_pkg.sv
verilog/inst_mem.sv
verilog/alu.sv
verilog/instruction_fetch.sv
verilog/decoder.sv
verilog/execute.sv
verilog/pat.sv
verification/pat_tb.sv

/* run.sh */
#!/bin/sh
# build the pat testbench with verilator, run it, then search the log for the fail banner
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pat_tb -f src.f -o pat_sim \
	&& ./obj_dir/pat_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
